// File: source/mem_stage_pkg.sv
//////////////////////////////////////////////////
// memory stage shared types and address map
//////////////////////////////////////////////////
`default_nettype none

package mem_stage_pkg;

  typedef logic [63:0] xlen_t;     // data word and address
  typedef logic [2:0]  funct3_t;   // [1:0] size, [2] zero-extend
  typedef logic [2:0]  byte_cnt_t; // bytes minus one

  typedef enum logic [1:0] {
    MEM_NONE  = 2'd0,
    MEM_LOAD  = 2'd1,
    MEM_STORE = 2'd2
  } mem_action_e;

  typedef enum logic {
    DC_READ  = 1'b0,
    DC_WRITE = 1'b1
  } dcache_op_e;

  // ram region, 256 MiB
  localparam xlen_t RAM_BASE = 64'h0000_0000_8000_0000;
  localparam xlen_t RAM_MASK = ~64'h0000_0000_0FFF_FFFF;

  // device page, 4 KiB
  localparam xlen_t DEV_BASE = 64'h0000_0000_2000_0000;
  localparam xlen_t DEV_MASK = ~64'h0000_0000_0000_0FFF;

  localparam logic [11:0] DEV_TIMER_OFS   = 12'h000;
  localparam logic [11:0] DEV_SCRATCH_OFS = 12'h008;

endpackage

`default_nettype wire

// File: source/load_extend.sv
//////////////////////////////////////////////////
// load data lane select and sign/zero extension
//////////////////////////////////////////////////
`default_nettype none

module load_extend
  import mem_stage_pkg::*;
(
  input  wire funct3_t    i_funct3,
  input  wire logic [2:0] i_addr_lo,
  input  wire xlen_t      i_raw,
  output xlen_t           o_data
);

  xlen_t shifted;
  logic  uns;

  // addressed lane down to bit 0
  assign shifted = i_raw >> {i_addr_lo, 3'b000};
  assign uns     = i_funct3[2];

  always_comb begin
    case (i_funct3[1:0])
      2'b00: begin
        o_data = uns ? {56'd0, shifted[7:0]} : {{56{shifted[7]}}, shifted[7:0]};
      end
      2'b01: begin
        o_data = uns ? {48'd0, shifted[15:0]} : {{48{shifted[15]}}, shifted[15:0]};
      end
      2'b10: begin
        o_data = uns ? {32'd0, shifted[31:0]} : {{32{shifted[31]}}, shifted[31:0]};
      end
      default: begin
        o_data = i_raw; // dword as is
      end
    endcase
  end

endmodule

`default_nettype wire

// File: source/mmio_devices.sv
//////////////////////////////////////////////////
// device page with free-running timer and
// a read/write scratch register
//////////////////////////////////////////////////
`default_nettype none

module mmio_devices
  import mem_stage_pkg::*;
(
  input  wire              clk,
  input  wire              rst,
  input  wire              i_ren,
  input  wire              i_wen,
  input  wire logic [11:0] i_addr,
  input  wire xlen_t       i_wdata,
  output xlen_t            o_rdata
);

  xlen_t timer;
  xlen_t scratch;

  always_ff @(posedge clk) begin
    if (rst) begin
      timer   <= '0;
      scratch <= '0;
    end else begin
      timer <= timer + 64'd1;
      // full dword writes only, timer is read-only
      if (i_wen && i_addr == DEV_SCRATCH_OFS) begin
        scratch <= i_wdata;
      end
    end
  end

  // registered read, sub-dword lanes picked by the stage
  always_ff @(posedge clk) begin
    if (i_ren) begin
      case (i_addr[11:3])
        DEV_TIMER_OFS[11:3]:   o_rdata <= timer;
        DEV_SCRATCH_OFS[11:3]: o_rdata <= scratch;
        default:               o_rdata <= '0; // hole in the page
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/mem_stage.sv
//////////////////////////////////////////////////
// memory access stage, routes loads and stores
// to the dcache port or the device page
//////////////////////////////////////////////////
`default_nettype none

module mem_stage
  import mem_stage_pkg::*;
(
  input  wire              clk,
  input  wire              rst,
  input  wire              i_ena,
  input  wire              i_ex_req,
  input  wire mem_action_e i_action,
  input  wire funct3_t     i_funct3,
  input  wire xlen_t       i_addr,
  input  wire xlen_t       i_wdata,
  output logic             o_ex_ack,
  output logic             o_wb_req,
  output xlen_t            o_wb_rdata,
  input  wire              i_wb_ack,
  output logic             o_dc_req,
  output dcache_op_e       o_dc_op,
  output xlen_t            o_dc_addr,
  output byte_cnt_t        o_dc_bytes,
  output xlen_t            o_dc_wdata,
  input  wire              i_dc_ack,
  input  wire xlen_t       i_dc_rdata
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CACHE,
    ST_DEV,
    ST_RESULT
  } state_e;

  state_e      state;
  mem_action_e action;
  logic        is_ram;
  logic        is_dev;
  byte_cnt_t   bytes;
  funct3_t     op_funct3;
  logic [2:0]  op_addr_lo;
  logic        res_dev;   // result taken from device read data
  xlen_t       res_q;
  logic        dev_ren;
  logic        dev_wen;
  logic [11:0] dev_addr;
  xlen_t       dev_wdata;
  xlen_t       dev_rdata;
  xlen_t       raw;
  xlen_t       ext;

  assign action = i_ena ? i_action : MEM_NONE;
  assign is_ram = (i_addr & RAM_MASK) == RAM_BASE;
  assign is_dev = (i_addr & DEV_MASK) == DEV_BASE;

  always_comb begin
    case (i_funct3[1:0])
      2'b00:   bytes = 3'd0; // byte
      2'b01:   bytes = 3'd1; // half
      2'b10:   bytes = 3'd3; // word
      default: bytes = 3'd7; // dword
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_IDLE;
      o_ex_ack <= 1'b0;
      o_wb_req <= 1'b0;
      o_dc_req <= 1'b0;
      dev_ren  <= 1'b0;
      dev_wen  <= 1'b0;
      res_dev  <= 1'b0;
    end else begin
      o_ex_ack <= (state == ST_IDLE) && i_ex_req && !o_ex_ack && !o_wb_req;
      dev_ren  <= 1'b0;
      dev_wen  <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (o_ex_ack) begin
            if (action != MEM_NONE && is_ram) begin
              o_dc_req <= 1'b1;
              res_dev  <= 1'b0;
              state    <= ST_CACHE;
            end else if (action != MEM_NONE && is_dev) begin
              dev_ren <= (action == MEM_LOAD);
              dev_wen <= (action == MEM_STORE);
              res_dev <= (action == MEM_LOAD);
              state   <= ST_DEV;
            end else begin
              // pass-through or unmapped, done right away
              res_dev  <= 1'b0;
              o_wb_req <= 1'b1;
              state    <= ST_RESULT;
            end
          end
        end
        ST_CACHE: begin
          if (i_dc_ack) begin
            o_dc_req <= 1'b0;
            o_wb_req <= 1'b1;
            state    <= ST_RESULT;
          end
        end
        ST_DEV: begin
          o_wb_req <= 1'b1; // device data lands this edge
          state    <= ST_RESULT;
        end
        ST_RESULT: begin
          if (i_wb_ack) begin
            o_wb_req <= 1'b0;
            state    <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // operand capture at the execute handshake
  always_ff @(posedge clk) begin
    if (o_ex_ack) begin
      o_dc_op    <= (action == MEM_STORE) ? DC_WRITE : DC_READ;
      o_dc_addr  <= i_addr;
      o_dc_bytes <= bytes;
      o_dc_wdata <= i_wdata;
      dev_addr   <= i_addr[11:0];
      dev_wdata  <= i_wdata;
      op_funct3  <= i_funct3;
      op_addr_lo <= i_addr[2:0];
      res_q      <= '0;
    end else if (state == ST_CACHE && i_dc_ack) begin
      res_q <= (o_dc_op == DC_READ) ? ext : '0;
    end
  end

  assign raw        = (state == ST_CACHE) ? i_dc_rdata : dev_rdata;
  assign o_wb_rdata = res_dev ? ext : res_q; // device read is held by mmio

  load_extend u_load_extend (
    .i_funct3  (op_funct3),
    .i_addr_lo (op_addr_lo),
    .i_raw     (raw),
    .o_data    (ext)
  );

  mmio_devices u_mmio_devices (
    .clk     (clk),
    .rst     (rst),
    .i_ren   (dev_ren),
    .i_wen   (dev_wen),
    .i_addr  (dev_addr),
    .i_wdata (dev_wdata),
    .o_rdata (dev_rdata)
  );

endmodule

`default_nettype wire

// File: source/data_ram.sv
//////////////////////////////////////////////////
// dcache stand-in, dword RAM with byte lanes
// and a fixed ack latency
//////////////////////////////////////////////////
`default_nettype none

module data_ram
  import mem_stage_pkg::*;
#(
  parameter int RAM_WORDS   = 256,
  parameter int RAM_LATENCY = 2
) (
  input  wire             clk,
  input  wire             rst,
  input  wire             i_req,
  input  wire dcache_op_e i_op,
  input  wire xlen_t      i_addr,
  input  wire byte_cnt_t  i_bytes,
  input  wire xlen_t      i_wdata,
  output logic            o_ack,
  output xlen_t           o_rdata
);

  localparam int IDX_W = $clog2(RAM_WORDS);

  xlen_t            mem [RAM_WORDS];
  logic [IDX_W-1:0] word_idx;
  logic [2:0]       cnt;       // cycles since request seen
  logic             fire;
  logic [2:0]       lane_lo;
  logic [3:0]       lane_hi;
  xlen_t            wdata_sh;

  assign word_idx = IDX_W'((i_addr >> 3) % RAM_WORDS);
  assign fire     = i_req && !o_ack && (cnt == 3'(RAM_LATENCY - 1));
  assign lane_lo  = i_addr[2:0];
  assign lane_hi  = {1'b0, lane_lo} + {1'b0, i_bytes};
  assign wdata_sh = i_wdata << {lane_lo, 3'b000}; // store bytes to their lanes

  always_ff @(posedge clk) begin
    if (rst) begin
      o_ack <= 1'b0;
      cnt   <= '0;
    end else if (o_ack) begin
      o_ack <= 1'b0; // single cycle ack
      cnt   <= '0;
    end else if (fire) begin
      o_ack <= 1'b1;
      cnt   <= '0;
    end else if (i_req) begin
      cnt <= cnt + 3'd1;
    end
  end

  // write lands on the ack edge
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < RAM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (o_ack && i_op == DC_WRITE) begin
      for (int b = 0; b < 8; b++) begin
        if (b >= lane_lo && b <= lane_hi) begin
          mem[word_idx][b*8 +: 8] <= wdata_sh[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      o_rdata <= mem[word_idx]; // whole aligned dword
    end
  end

endmodule

`default_nettype wire

// File: source/mem_subsys_top.sv
//////////////////////////////////////////////////
// memory stage with its data RAM model
//////////////////////////////////////////////////
`default_nettype none

module mem_subsys_top
  import mem_stage_pkg::*;
#(
  parameter int RAM_WORDS   = 256,
  parameter int RAM_LATENCY = 2   // 1 to 7
) (
  input  wire              clk,
  input  wire              rst,
  input  wire              i_ena,
  input  wire              i_ex_req,
  input  wire mem_action_e i_action,
  input  wire funct3_t     i_funct3,
  input  wire xlen_t       i_addr,
  input  wire xlen_t       i_wdata,
  input  wire              i_wb_ack,
  output logic             o_ex_ack,
  output logic             o_wb_req,
  output xlen_t            o_wb_rdata
);

  // dcache port
  logic       dc_req;
  dcache_op_e dc_op;
  xlen_t      dc_addr;
  byte_cnt_t  dc_bytes;
  xlen_t      dc_wdata;
  logic       dc_ack;
  xlen_t      dc_rdata;

  mem_stage u_mem_stage (
    .clk        (clk),
    .rst        (rst),
    .i_ena      (i_ena),
    .i_ex_req   (i_ex_req),
    .i_action   (i_action),
    .i_funct3   (i_funct3),
    .i_addr     (i_addr),
    .i_wdata    (i_wdata),
    .o_ex_ack   (o_ex_ack),
    .o_wb_req   (o_wb_req),
    .o_wb_rdata (o_wb_rdata),
    .i_wb_ack   (i_wb_ack),
    .o_dc_req   (dc_req),
    .o_dc_op    (dc_op),
    .o_dc_addr  (dc_addr),
    .o_dc_bytes (dc_bytes),
    .o_dc_wdata (dc_wdata),
    .i_dc_ack   (dc_ack),
    .i_dc_rdata (dc_rdata)
  );

  data_ram #(
    .RAM_WORDS   (RAM_WORDS),
    .RAM_LATENCY (RAM_LATENCY)
  ) u_data_ram (
    .clk     (clk),
    .rst     (rst),
    .i_req   (dc_req),
    .i_op    (dc_op),
    .i_addr  (dc_addr),
    .i_bytes (dc_bytes),
    .i_wdata (dc_wdata),
    .o_ack   (dc_ack),
    .o_rdata (dc_rdata)
  );

endmodule

`default_nettype wire

// File: dv/mem_subsys_tb.sv
//////////////////////////////////////////////////
// table-driven testbench for the memory subsystem
//////////////////////////////////////////////////
`default_nettype none

module mem_subsys_tb
  import mem_stage_pkg::*;
();

  localparam int RAM_WORDS   = 256;
  localparam int RAM_LATENCY = 2;
  localparam int RAM_BYTES   = RAM_WORDS * 8;
  localparam int TIMEOUT     = 100;
  localparam int MAX_ROWS    = 48;
  localparam int CHK_EXP     = 0; // fixed expected value
  localparam int CHK_MODEL   = 1; // expected from RAM model
  localparam int CHK_TIMER   = 2;
  localparam funct3_t F_B  = 3'd0;
  localparam funct3_t F_H  = 3'd1;
  localparam funct3_t F_W  = 3'd2;
  localparam funct3_t F_D  = 3'd3;
  localparam funct3_t F_BU = 3'd4;
  localparam funct3_t F_HU = 3'd5;
  localparam funct3_t F_WU = 3'd6;

  logic        clk;
  logic        rst;
  logic        i_ena;
  logic        i_ex_req;
  mem_action_e i_action;
  funct3_t     i_funct3;
  xlen_t       i_addr;
  xlen_t       i_wdata;
  logic        i_wb_ack;
  logic        o_ex_ack;
  logic        o_wb_req;
  xlen_t       o_wb_rdata;

  // stimulus table
  mem_action_e t_act   [MAX_ROWS];
  funct3_t     t_f3    [MAX_ROWS];
  xlen_t       t_addr  [MAX_ROWS];
  xlen_t       t_wdata [MAX_ROWS];
  int          t_stall [MAX_ROWS];
  logic        t_ena   [MAX_ROWS];
  int          t_chk   [MAX_ROWS];
  xlen_t       t_exp   [MAX_ROWS];
  int          n_rows;

  logic [7:0]  ref_mem [RAM_BYTES];
  logic [31:0] lcg_state;
  xlen_t       last_timer;

  mem_subsys_top #(
    .RAM_WORDS   (RAM_WORDS),
    .RAM_LATENCY (RAM_LATENCY)
  ) uut (
    .clk        (clk),
    .rst        (rst),
    .i_ena      (i_ena),
    .i_ex_req   (i_ex_req),
    .i_action   (i_action),
    .i_funct3   (i_funct3),
    .i_addr     (i_addr),
    .i_wdata    (i_wdata),
    .i_wb_ack   (i_wb_ack),
    .o_ex_ack   (o_ex_ack),
    .o_wb_req   (o_wb_req),
    .o_wb_rdata (o_wb_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic xlen_t rand64();
    xlen_t v;
    v[63:32] = next_rand();
    v[31:0]  = next_rand();
    return v;
  endfunction

  function automatic logic in_ram(input xlen_t addr);
    return (addr & RAM_MASK) == RAM_BASE;
  endfunction

  function automatic int ram_ofs(input xlen_t addr);
    return int'((addr - RAM_BASE) % RAM_BYTES); // window repeats across the region
  endfunction

  function automatic void model_store(input xlen_t addr, input funct3_t f3, input xlen_t data);
    int size;
    int ofs;
    size = 1 << f3[1:0];
    ofs  = ram_ofs(addr);
    for (int b = 0; b < size; b++) begin
      ref_mem[ofs + b] = data[8*b +: 8];
    end
  endfunction

  function automatic xlen_t model_load(input xlen_t addr, input funct3_t f3);
    xlen_t v;
    int    size;
    int    ofs;
    v    = '0;
    size = 1 << f3[1:0];
    ofs  = ram_ofs(addr);
    for (int b = 0; b < size; b++) begin
      v[8*b +: 8] = ref_mem[ofs + b];
    end
    if (!f3[2] && size < 8 && v[8*size-1]) begin
      v = v | ~((64'd1 << (8 * size)) - 64'd1); // copy the sign bit upward
    end
    return v;
  endfunction

  task automatic add_row(input mem_action_e act, input funct3_t f3, input xlen_t addr,
                         input xlen_t wdata, input int stall, input logic ena,
                         input int chk, input xlen_t exp);
    t_act[n_rows]   = act;
    t_f3[n_rows]    = f3;
    t_addr[n_rows]  = addr;
    t_wdata[n_rows] = wdata;
    t_stall[n_rows] = stall;
    t_ena[n_rows]   = ena;
    t_chk[n_rows]   = chk;
    t_exp[n_rows]   = exp;
    n_rows++;
  endtask

  task automatic build_table();
    n_rows = 0;
    // dword store and reload, pass-through
    add_row(MEM_STORE, F_D, 64'h8000_0000, rand64(), 0, 1'b1, CHK_EXP, 64'd0);
    add_row(MEM_LOAD, F_D, 64'h8000_0000, 64'd0, 2, 1'b1, CHK_MODEL, 64'd0);
    add_row(MEM_NONE, F_D, 64'h8000_0000, rand64(), 0, 1'b1, CHK_EXP, 64'd0);
    // partial stores at several lanes
    add_row(MEM_STORE, F_D, 64'h8000_0080, rand64(), 0, 1'b1, CHK_EXP, 64'd0);
    add_row(MEM_STORE, F_B, 64'h8000_0083, rand64(), 0, 1'b1, CHK_EXP, 64'd0);
    add_row(MEM_STORE, F_H, 64'h8000_0086, rand64(), 1, 1'b1, CHK_EXP, 64'd0);
    add_row(MEM_STORE, F_B, 64'h8000_0085, rand64(), 0, 1'b1, CHK_EXP, 64'd0);
    add_row(MEM_LOAD, F_D, 64'h8000_0080, 64'd0, 0, 1'b1, CHK_MODEL, 64'd0);
    add_row(MEM_STORE, F_D, 64'h8000_0088, rand64(), 0, 1'b1, CHK_EXP, 64'd0);
    add_row(MEM_STORE, F_W, 64'h8000_008C, rand64(), 0, 1'b1, CHK_EXP, 64'd0);
    add_row(MEM_STORE, F_H, 64'h8000_008A, rand64(), 0, 1'b1, CHK_EXP, 64'd0);
    add_row(MEM_STORE, F_B, 64'h8000_0088, rand64(), 0, 1'b1, CHK_EXP, 64'd0);
    add_row(MEM_LOAD, F_D, 64'h8000_0088, 64'd0, 0, 1'b1, CHK_MODEL, 64'd0);
    add_row(MEM_LOAD, F_HU, 64'h8000_008A, 64'd0, 0, 1'b1, CHK_MODEL, 64'd0);
    add_row(MEM_LOAD, F_B, 64'h8000_0085, 64'd0, 0, 1'b1, CHK_MODEL, 64'd0);
    // sign and zero extension on known bytes
    add_row(MEM_STORE, F_D, 64'h8000_0040, 64'h7A6B_5C4D_8E3F_9012, 0, 1'b1, CHK_EXP, 64'd0);
    add_row(MEM_LOAD, F_B, 64'h8000_0040, 64'd0, 0, 1'b1, CHK_EXP, 64'h12);
    add_row(MEM_LOAD, F_B, 64'h8000_0041, 64'd0, 0, 1'b1, CHK_EXP, 64'hFFFF_FFFF_FFFF_FF90);
    add_row(MEM_LOAD, F_BU, 64'h8000_0041, 64'd0, 0, 1'b1, CHK_EXP, 64'h90);
    add_row(MEM_LOAD, F_H, 64'h8000_0042, 64'd0, 0, 1'b1, CHK_EXP, 64'hFFFF_FFFF_FFFF_8E3F);
    add_row(MEM_LOAD, F_HU, 64'h8000_0042, 64'd0, 0, 1'b1, CHK_EXP, 64'h8E3F);
    add_row(MEM_LOAD, F_H, 64'h8000_0044, 64'd0, 0, 1'b1, CHK_EXP, 64'h5C4D);
    add_row(MEM_LOAD, F_W, 64'h8000_0040, 64'd0, 0, 1'b1, CHK_EXP, 64'hFFFF_FFFF_8E3F_9012);
    add_row(MEM_LOAD, F_WU, 64'h8000_0040, 64'd0, 0, 1'b1, CHK_EXP, 64'h8E3F_9012);
    add_row(MEM_LOAD, F_W, 64'h8000_0044, 64'd0, 0, 1'b1, CHK_EXP, 64'h7A6B_5C4D);
    // device page
    add_row(MEM_STORE, F_D, 64'h2000_0008, 64'h0123_4567_89AB_CDEF, 0, 1'b1, CHK_EXP, 64'd0);
    add_row(MEM_LOAD, F_D, 64'h2000_0008, 64'd0, 4, 1'b1, CHK_EXP, 64'h0123_4567_89AB_CDEF);
    add_row(MEM_LOAD, F_D, 64'h2000_0010, 64'd0, 0, 1'b1, CHK_EXP, 64'd0);
    add_row(MEM_LOAD, F_D, 64'h2000_0000, 64'd0, 3, 1'b1, CHK_TIMER, 64'd0);
    add_row(MEM_LOAD, F_D, 64'h2000_0000, 64'd0, 0, 1'b1, CHK_TIMER, 64'd0);
    // unmapped and disabled accesses
    add_row(MEM_LOAD, F_D, 64'h1000_0000, 64'd0, 0, 1'b1, CHK_EXP, 64'd0);
    add_row(MEM_LOAD, F_W, 64'h9000_0000, 64'd0, 0, 1'b1, CHK_EXP, 64'd0);
    add_row(MEM_STORE, F_D, 64'h4000_0000, rand64(), 0, 1'b1, CHK_EXP, 64'd0);
    add_row(MEM_LOAD, F_D, 64'h8000_0000, 64'd0, 0, 1'b0, CHK_EXP, 64'd0);
    add_row(MEM_STORE, F_D, 64'h8000_0000, rand64(), 0, 1'b0, CHK_EXP, 64'd0);
    add_row(MEM_LOAD, F_D, 64'h8000_0000, 64'd0, 5, 1'b1, CHK_MODEL, 64'd0);
  endtask

  task automatic abort_run();
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input xlen_t act, input xlen_t exp);
    assert (act === exp) else begin
      $display("CHECK FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_result(input int i, input xlen_t got);
    if (t_chk[i] == CHK_TIMER) begin
      assert (got != '0 && got > last_timer) else begin
        $display("CHECK FAILED t=%0t o_wb_rdata expected timer above %h actual %h",
                 $time, last_timer, got);
        abort_run();
      end
      last_timer = got;
    end else if (t_chk[i] == CHK_MODEL) begin
      check_val("o_wb_rdata", got, model_load(t_addr[i], t_f3[i]));
    end else begin
      check_val("o_wb_rdata", got, t_exp[i]);
    end
  endtask

  task automatic present(input int i);
    i_ex_req <= 1'b1;
    i_ena    <= t_ena[i];
    i_action <= t_act[i];
    i_funct3 <= t_f3[i];
    i_addr   <= t_addr[i];
    i_wdata  <= t_wdata[i];
  endtask

  task automatic wait_ex_ack();
    int n;
    n = 0;
    @(negedge clk);
    while (!o_ex_ack) begin
      if (n == TIMEOUT) begin
        $display("timeout at t=%0t, execute request never acknowledged", $time);
        abort_run();
      end
      n++;
      @(negedge clk);
    end
  endtask

  task automatic wait_wb_req();
    int n;
    n = 0;
    @(negedge clk);
    while (!o_wb_req) begin
      if (n == TIMEOUT) begin
        $display("timeout at t=%0t, no writeback request after execute handshake", $time);
        abort_run();
      end
      n++;
      @(negedge clk);
    end
  endtask

  initial begin
    xlen_t got;
    rst        = 1'b1;
    i_ena      = 1'b0;
    i_ex_req   = 1'b0;
    i_action   = MEM_NONE;
    i_funct3   = '0;
    i_addr     = '0;
    i_wdata    = '0;
    i_wb_ack   = 1'b0;
    lcg_state  = 32'h7fbeeb8a;
    last_timer = '0;
    for (int b = 0; b < RAM_BYTES; b++) begin
      ref_mem[b] = 8'h00;
    end
    build_table();
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    present(0);
    for (int i = 0; i < n_rows; i++) begin
      wait_ex_ack();
      @(posedge clk);
      i_ex_req <= 1'b0;
      wait_wb_req();
      got = o_wb_rdata;
      check_result(i, got);
      if (t_ena[i] && t_act[i] == MEM_STORE && in_ram(t_addr[i])) begin
        model_store(t_addr[i], t_f3[i], t_wdata[i]);
      end
      @(posedge clk);
      if (i + 1 < n_rows) begin
        present(i + 1); // queued behind the held result
      end
      for (int s = 0; s < t_stall[i]; s++) begin
        @(negedge clk);
        check_val("o_wb_req", xlen_t'(o_wb_req), 64'd1);
        check_val("o_wb_rdata", o_wb_rdata, got);
        check_val("o_ex_ack", xlen_t'(o_ex_ack), 64'd0);
        @(posedge clk);
      end
      i_wb_ack <= 1'b1;
      @(posedge clk);
      i_wb_ack <= 1'b0;
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: mem_subsys_top.f
source/mem_stage_pkg.sv
source/load_extend.sv
source/mmio_devices.sv
source/mem_stage.sv
source/data_ram.sv
source/mem_subsys_top.sv
dv/mem_subsys_tb.sv

// File: Bender.yml
package:
  name: mem_subsys

sources:
  - source/mem_stage_pkg.sv
  - source/load_extend.sv
  - source/mmio_devices.sv
  - source/mem_stage.sv
  - source/data_ram.sv
  - source/mem_subsys_top.sv
  - target: test
    files:
      - dv/mem_subsys_tb.sv
